/* source/lsu_pkg.sv */
package lsu_pkg;

	// 17 opcodes do not fit in 4 bits, so the field is 5 bits wide
	typedef enum logic [4:0]
	{
		op_nop   = 5'd0,
		op_lb    = 5'd1,
		op_lbu   = 5'd2,
		op_lh    = 5'd3,
		op_lhu   = 5'd4,
		op_lw    = 5'd5,
		op_sb    = 5'd6,
		op_sh    = 5'd7,
		op_sw    = 5'd8,
		op_mult  = 5'd9,
		op_multu = 5'd10,
		op_div   = 5'd11,
		op_divu  = 5'd12,
		op_mthi  = 5'd13,
		op_mtlo  = 5'd14,
		op_mfhi  = 5'd15,
		op_mflo  = 5'd16
	} op_e;

	typedef enum logic [1:0]
	{
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} size_e;

	// bit 1 selects divide, bit 0 selects signed
	typedef enum logic [1:0]
	{
		md_multu = 2'b00,
		md_mult  = 2'b01,
		md_divu  = 2'b10,
		md_div   = 2'b11
	} muldiv_e;

	localparam logic [31:0] sram_base = 32'hA000_0000; // start of data window
	localparam int div_cycles = 34; // magnitudes + 32 steps + sign fix

endpackage

/* source/op_if.sv */
`timescale 1ns/1ps

interface op_if;
	import lsu_pkg::*;

	logic    mem_rd;     // load access
	logic    mem_wr;     // store access
	size_e   size;
	logic    sign_ext;   // lb / lh
	logic    md_start;   // already masked by flush
	muldiv_e md_op;
	logic    hilo_wr;    // mthi / mtlo, masked by flush
	logic    hilo_wr_hi;
	logic    hilo_rd_hi; // mfhi selects hi

	modport dec_mp (
		output mem_rd, mem_wr, size, sign_ext,
		output md_start, md_op, hilo_wr, hilo_wr_hi, hilo_rd_hi
	);

	modport mem_mp (
		input mem_rd, mem_wr, size, sign_ext
	);

	modport md_mp (
		input md_start, md_op, hilo_wr, hilo_wr_hi, hilo_rd_hi
	);

endinterface

/* source/op_decode.sv */
`timescale 1ns/1ps

module op_decode (
	input lsu_pkg::op_e op,
	input logic         flush,
	op_if.dec_mp        dec
);
	import lsu_pkg::*;

	logic is_md;
	logic is_mt;

	assign is_md = op inside {op_mult, op_multu, op_div, op_divu};
	assign is_mt = op inside {op_mthi, op_mtlo};

	// memory side
	assign dec.mem_rd   = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
	assign dec.mem_wr   = op inside {op_sb, op_sh, op_sw};
	assign dec.sign_ext = op inside {op_lb, op_lh};

	always_comb
	begin
		case (op)
			op_lb, op_lbu, op_sb:
				dec.size = size_byte;
			op_lh, op_lhu, op_sh:
				dec.size = size_half;
			default:
				dec.size = size_word;
		endcase
	end

	always_comb
	begin
		case (op)
			op_mult:
				dec.md_op = md_mult;
			op_div:
				dec.md_op = md_div;
			op_divu:
				dec.md_op = md_divu;
			default:
				dec.md_op = md_multu;
		endcase
	end

	// a flushed op must not touch hi/lo
	assign dec.md_start = is_md & ~flush;
	assign dec.hilo_wr  = is_mt & ~flush;

	assign dec.hilo_wr_hi = (op == op_mthi);
	assign dec.hilo_rd_hi = (op == op_mfhi); // mflo and others read lo

endmodule

/* source/store_lane.sv */
`timescale 1ns/1ps

module store_lane (
	op_if.mem_mp        st,
	input  logic [31:0] addr,
	input  logic [31:0] wdata_in,
	output logic        sram_en,
	output logic [3:0]  sram_wen,
	output logic [31:0] sram_addr,
	output logic [31:0] sram_wdata
);
	import lsu_pkg::*;

	assign sram_en = st.mem_rd | st.mem_wr;

	// physical address inside the sram window
	assign sram_addr = {addr[31:2], 2'b00} - sram_base;

	always_comb
	begin
		sram_wen = 4'b0000;
		if (st.mem_wr)
		begin
			case (st.size)
				size_byte:
					sram_wen = 4'b0001 << addr[1:0];
				size_half:
					sram_wen = addr[1] ? 4'b1100 : 4'b0011;
				default:
					sram_wen = 4'b1111;
			endcase
		end
	end

	// lanes not enabled carry don't-care copies
	always_comb
	begin
		case (st.size)
			size_byte:
				sram_wdata = {4{wdata_in[7:0]}};
			size_half:
				sram_wdata = {2{wdata_in[15:0]}};
			default:
				sram_wdata = wdata_in;
		endcase
	end

endmodule

/* source/hilo_unit.sv */
`timescale 1ns/1ps

module hilo_unit (
	input  logic        clk,
	input  logic        rst,
	op_if.md_mp         md,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic        busy,
	output logic [31:0] hilo_data
);
	import lsu_pkg::*;

	typedef enum logic {st_free, st_busy} state_e;

	state_e state;
	logic [$clog2(div_cycles)-1:0] cnt;
	logic [31:0] hi;
	logic [31:0] lo;

	logic        mul_go;
	logic        div_go;
	logic        div_done;
	logic [63:0] mul_a;
	logic [63:0] mul_b;
	logic [63:0] prod;

	logic [31:0] dvd_q; // operands held for the whole divide
	logic [31:0] dvs_q;
	logic        sgn_q;
	logic [31:0] rem;
	logic [31:0] quo;
	logic [31:0] mag;   // divisor magnitude
	logic [32:0] trial;
	logic        neg_quo;
	logic        neg_rem;
	logic [31:0] quo_fix;
	logic [31:0] rem_fix;

	assign busy = (state == st_busy);

	// ops arriving while busy are dropped
	assign mul_go   = md.md_start & ~md.md_op[1] & ~busy;
	assign div_go   = md.md_start & md.md_op[1] & ~busy;
	assign div_done = busy && (cnt == div_cycles - 1);

	// single multiplier, operands extended by sign or zero
	assign mul_a = (md.md_op == md_mult) ? {{32{a[31]}}, a} : {32'b0, a};
	assign mul_b = (md.md_op == md_mult) ? {{32{b[31]}}, b} : {32'b0, b};
	assign prod  = mul_a * mul_b;

	assign trial = {rem, quo[31]} - {1'b0, mag};

	assign neg_quo = sgn_q & (dvd_q[31] ^ dvs_q[31]);
	assign neg_rem = sgn_q & dvd_q[31]; // remainder follows dividend
	assign quo_fix = neg_quo ? -quo : quo;
	assign rem_fix = neg_rem ? -rem : rem;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= st_free;
			cnt   <= '0;
		end
		else if (div_go)
		begin
			state <= st_busy;
			cnt   <= '0;
		end
		else if (div_done)
			state <= st_free;
		else if (busy)
			cnt <= cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (div_go)
		begin
			dvd_q <= a;
			dvs_q <= b;
			sgn_q <= md.md_op[0];
		end
		else if (busy && cnt == 0)
		begin
			// take magnitudes
			rem <= '0;
			quo <= (sgn_q & dvd_q[31]) ? -dvd_q : dvd_q;
			mag <= (sgn_q & dvs_q[31]) ? -dvs_q : dvs_q;
		end
		else if (busy && !div_done)
		begin
			if (!trial[32])
			begin
				rem <= trial[31:0];
				quo <= {quo[30:0], 1'b1};
			end
			else
			begin
				rem <= {rem[30:0], quo[31]};
				quo <= {quo[30:0], 1'b0};
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			hi <= '0;
			lo <= '0;
		end
		else if (mul_go)
			{hi, lo} <= prod;
		else if (div_done)
		begin
			hi <= rem_fix;
			lo <= quo_fix;
		end
		else if (md.hilo_wr && !busy)
		begin
			if (md.hilo_wr_hi)
				hi <= a;
			else
				lo <= a;
		end
	end

	assign hilo_data = md.hilo_rd_hi ? hi : lo;

endmodule

/* source/load_extract.sv */
`timescale 1ns/1ps

module load_extract (
	input  logic        clk,
	input  logic        rst,
	op_if.mem_mp        ld,
	input  logic [1:0]  addr_lo,
	input  logic [31:0] sram_rdata,
	output logic        load_valid,
	output logic [31:0] load_data
);
	import lsu_pkg::*;

	size_e       size_q;
	logic        sign_q;
	logic [1:0]  lo_q;
	logic [7:0]  byte_sel;
	logic [15:0] half_sel;

	// read data arrives one cycle after the request
	always_ff @(posedge clk)
	begin
		if (!rst)
			load_valid <= 1'b0;
		else
			load_valid <= ld.mem_rd;
	end

	always_ff @(posedge clk)
	begin
		if (ld.mem_rd)
		begin
			size_q <= ld.size;
			sign_q <= ld.sign_ext;
			lo_q   <= addr_lo;
		end
	end

	assign byte_sel = sram_rdata[8*lo_q +: 8];
	assign half_sel = lo_q[1] ? sram_rdata[31:16] : sram_rdata[15:0];

	always_comb
	begin
		case (size_q)
			size_byte:
				load_data = {{24{sign_q & byte_sel[7]}}, byte_sel};
			size_half:
				load_data = {{16{sign_q & half_sel[15]}}, half_sel};
			default:
				load_data = sram_rdata; // word as is
		endcase
	end

endmodule

/* source/mem_muldiv_top.sv */
`timescale 1ns/1ps

module mem_muldiv_top (
	input  logic         clk,
	input  logic         rst,
	input  lsu_pkg::op_e op,
	input  logic [31:0]  a,
	input  logic [31:0]  b,
	input  logic [31:0]  addr,
	input  logic         flush,
	input  logic [31:0]  sram_rdata,
	output logic         sram_en,
	output logic [3:0]   sram_wen,
	output logic [31:0]  sram_addr,
	output logic [31:0]  sram_wdata,
	output logic         load_valid,
	output logic [31:0]  load_data,
	output logic [31:0]  hilo_data,
	output logic         busy
);

	op_if op_bus ();

	op_decode u_decode (
		.op    (op),
		.flush (flush),
		.dec   (op_bus.dec_mp)
	);

	// store data comes from operand b
	store_lane u_store (
		.st         (op_bus.mem_mp),
		.addr       (addr),
		.wdata_in   (b),
		.sram_en    (sram_en),
		.sram_wen   (sram_wen),
		.sram_addr  (sram_addr),
		.sram_wdata (sram_wdata)
	);

	hilo_unit u_hilo (
		.clk       (clk),
		.rst       (rst),
		.md        (op_bus.md_mp),
		.a         (a),
		.b         (b),
		.busy      (busy),
		.hilo_data (hilo_data)
	);

	load_extract u_load (
		.clk        (clk),
		.rst        (rst),
		.ld         (op_bus.mem_mp),
		.addr_lo    (addr[1:0]), // byte offset for lane select
		.sram_rdata (sram_rdata),
		.load_valid (load_valid),
		.load_data  (load_data)
	);

endmodule

/* tests/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
	input  logic         clk,
	input  logic         rst,
	input  lsu_pkg::op_e op,
	input  logic [31:0]  a,
	input  logic [31:0]  b,
	input  logic [31:0]  addr,
	input  logic         flush,
	input  logic         sram_en,
	input  logic [3:0]   sram_wen,
	input  logic [31:0]  sram_addr,
	input  logic [31:0]  sram_wdata,
	input  logic         load_valid,
	input  logic [31:0]  load_data,
	input  logic [31:0]  hilo_data,
	input  logic         busy,
	output int           mem_errs,
	output int           hilo_errs
);
	import lsu_pkg::*;

	logic [31:0] mem_ref [256]; // shadow of the sram contents
	logic [31:0] hi_ref = '0;
	logic [31:0] lo_ref = '0;
	logic [63:0] div_res;       // {rem, quo} of the running divide
	int          div_left = 0;
	logic        ld_pend = 1'b0;
	op_e         ld_op;
	logic [1:0]  ld_lo;
	logic [31:0] ld_word;
	logic        is_ld;
	logic        is_st;
	logic [31:0] exp_addr;
	logic [3:0]  exp_wen;
	logic [31:0] exp_wdata;
	int          n_mem = 0;
	int          n_hilo = 0;

	assign mem_errs  = n_mem;
	assign hilo_errs = n_hilo;

	function automatic int compare(string name, logic [31:0] exp, logic [31:0] got);
		if (got === exp)
			return 0;
		$display("ERR %s exp=%h got=%h t=%0t", name, exp, got, $time);
		return 1;
	endfunction

	function automatic logic [3:0] wen_ref(op_e o, logic [1:0] lo);
		if (o == op_sw)
			return 4'b1111;
		if (o == op_sh)
			return lo[1] ? 4'b1100 : 4'b0011;
		return 4'b0001 << lo;
	endfunction

	function automatic logic [31:0] wdata_ref(op_e o, logic [31:0] v);
		if (o == op_sb)
			return {v[7:0], v[7:0], v[7:0], v[7:0]};
		if (o == op_sh)
			return {v[15:0], v[15:0]};
		return v;
	endfunction

	function automatic logic [31:0] load_ref(op_e o, logic [31:0] w, logic [1:0] lo);
		logic [7:0]  bt;
		logic [15:0] hw;
		bt = 8'(w >> (8 * lo));
		hw = lo[1] ? w[31:16] : w[15:0];
		case (o)
			op_lb:   return {{24{bt[7]}}, bt};
			op_lbu:  return {24'b0, bt};
			op_lh:   return {{16{hw[15]}}, hw};
			op_lhu:  return {16'b0, hw};
			default: return w;
		endcase
	endfunction

	function automatic logic [63:0] mul_ref(op_e o, logic [31:0] x, logic [31:0] y);
		longint sx;
		longint sy;
		sx = (o == op_mult) ? longint'($signed(x)) : longint'({32'b0, x});
		sy = (o == op_mult) ? longint'($signed(y)) : longint'({32'b0, y});
		return sx * sy; // low 64 bits are the product either way
	endfunction

	// 64-bit math keeps the most negative dividend safe
	function automatic logic [63:0] div_ref(op_e o, logic [31:0] x, logic [31:0] y);
		longint n;
		longint d;
		n = (o == op_div) ? longint'($signed(x)) : longint'({32'b0, x});
		d = (o == op_div) ? longint'($signed(y)) : longint'({32'b0, y});
		return {32'(n % d), 32'(n / d)};
	endfunction

	always @(posedge clk)
	begin
		is_ld     = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
		is_st     = op inside {op_sb, op_sh, op_sw};
		exp_addr  = (addr & 32'hFFFF_FFFC) - sram_base;
		exp_wen   = is_st ? wen_ref(op, addr[1:0]) : 4'b0000;
		exp_wdata = wdata_ref(op, b);
		if (!rst)
		begin
			hi_ref   = '0;
			lo_ref   = '0;
			div_left = 0;
			ld_pend  = 1'b0;
		end
		else
		begin
			n_mem += compare("sram_en", 32'(is_ld | is_st), 32'(sram_en));
			n_mem += compare("sram_wen", 32'(exp_wen), 32'(sram_wen));
			if (is_ld | is_st)
				n_mem += compare("sram_addr", exp_addr, sram_addr);
			if (is_st)
			begin
				n_mem += compare("sram_wdata", exp_wdata, sram_wdata);
				for (int i = 0; i < 4; i++)
					if (exp_wen[i])
						mem_ref[exp_addr[9:2]][8*i +: 8] = exp_wdata[8*i +: 8];
			end
			n_mem += compare("load_valid", 32'(ld_pend), 32'(load_valid));
			if (ld_pend)
				n_mem += compare("load_data", load_ref(ld_op, ld_word, ld_lo), load_data);
			ld_pend = is_ld;
			ld_op   = op;
			ld_lo   = addr[1:0];
			ld_word = mem_ref[exp_addr[9:2]]; // word as the sram will return it

			n_hilo += compare("busy", 32'(div_left != 0), 32'(busy));
			if (op == op_mfhi)
				n_hilo += compare("hilo_data", hi_ref, hilo_data);
			if (op == op_mflo)
				n_hilo += compare("hilo_data", lo_ref, hilo_data);
			if (div_left != 0)
			begin
				div_left--;
				if (div_left == 0)
					{hi_ref, lo_ref} = div_res; // hi gets remainder
			end
			else if (!flush)
			begin
				case (op)
					op_mult, op_multu:
						{hi_ref, lo_ref} = mul_ref(op, a, b);
					op_div, op_divu:
					begin
						div_res  = div_ref(op, a, b);
						div_left = div_cycles;
					end
					op_mthi:
						hi_ref = a;
					op_mtlo:
						lo_ref = a;
					default:
						;
				endcase
			end
		end
	end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
	import lsu_pkg::*;

	logic        clk = 1'b0;
	logic        rst = 1'b0;
	op_e         op = op_nop;
	logic [31:0] a = '0;
	logic [31:0] b = '0;
	logic [31:0] addr = '0;
	logic        flush = 1'b0;
	logic [31:0] sram_rdata = '0;
	logic        sram_en;
	logic [3:0]  sram_wen;
	logic [31:0] sram_addr;
	logic [31:0] sram_wdata;
	logic        load_valid;
	logic [31:0] load_data;
	logic [31:0] hilo_data;
	logic        busy;
	logic [31:0] sram [256];
	int          mem_errs;
	int          hilo_errs;
	int          timeouts = 0;
	int unsigned x;
	int unsigned y;
	op_e         o;
	op_e         mem_ops [8] = '{op_sb, op_sh, op_sw, op_lb, op_lbu, op_lh, op_lhu, op_lw};

	always #20 clk = ~clk;

	mem_muldiv_top UUT (.*);

	tb_checker u_chk (.*);

	// byte-wise writes and registered read data
	always @(posedge clk)
	begin
		if (sram_en)
		begin
			for (int i = 0; i < 4; i++)
				if (sram_wen[i])
					sram[sram_addr[9:2]][8*i +: 8] <= sram_wdata[8*i +: 8];
			sram_rdata <= sram[sram_addr[9:2]];
		end
	end

	task automatic issue(op_e c, logic [31:0] va, logic [31:0] vb, logic [31:0] ad, logic fl);
		@(negedge clk);
		op    = c;
		a     = va;
		b     = vb;
		addr  = ad;
		flush = fl;
	endtask

	task automatic wait_idle(int limit);
		int n;
		n = 0;
		while (busy && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (busy)
		begin
			$display("timeout: divider still busy after %0d cycles", n);
			timeouts++;
		end
	endtask

	function automatic logic [31:0] win_addr(int unsigned idx, int unsigned lo);
		return sram_base + 4 * (idx % 256) + (lo % 4);
	endfunction

	initial
	begin
		x = $urandom(26961);
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		issue(op_mfhi, 0, 0, 0, 0); // hi/lo cleared by reset
		issue(op_mflo, 0, 0, 0, 0);
		for (int i = 0; i < 256; i++)
			issue(op_sw, 0, $urandom, win_addr(i, 0), 0);
		// mixed traffic on a few words so loads hit recent stores
		for (int i = 0; i < 400; i++)
		begin
			o = mem_ops[$urandom % 8];
			y = $urandom % 4;
			if (o inside {op_sh, op_lh, op_lhu})
				y = y & 2;
			issue(o, 0, $urandom, win_addr($urandom % 32, y), 0);
		end
		for (int i = 0; i < 50; i++)
		begin
			issue((i % 2) ? op_multu : op_mult, $urandom, $urandom, 0, 0);
			issue(op_mfhi, 0, 0, 0, 0);
			issue(op_mflo, 0, 0, 0, 0);
		end
		for (int i = 0; i < 24; i++)
		begin
			x = (i == 0) ? 32'h8000_0000 : $urandom;
			y = (i % 3 == 0) ? $urandom : ($urandom % 200) - 100; // small, either sign
			if (i == 0)
				y = 32'hFFFF_FFFF;
			if (y == 0)
				y = 3;
			issue((i % 2) ? op_divu : op_div, x, y, 0, 0);
			issue(op_mult, $urandom, $urandom, 0, 0); // dropped while busy
			issue(op_mtlo, $urandom, 0, 0, 0);
			issue(op_mfhi, 0, 0, 0, 0); // old values while busy
			issue(op_mflo, 0, 0, 0, 0);
			wait_idle(div_cycles + 8);
			issue(op_mfhi, 0, 0, 0, 0);
			issue(op_mflo, 0, 0, 0, 0);
		end
		issue(op_mthi, $urandom, 0, 0, 0);
		issue(op_mtlo, $urandom, 0, 0, 0);
		issue(op_mfhi, 0, 0, 0, 0);
		issue(op_mflo, 0, 0, 0, 0);
		issue(op_mult, $urandom, $urandom, 0, 1);
		issue(op_div, $urandom, 5, 0, 1);
		issue(op_mthi, $urandom, 0, 0, 1);
		issue(op_mtlo, $urandom, 0, 0, 1);
		issue(op_mfhi, 0, 0, 0, 0);
		issue(op_mflo, 0, 0, 0, 0);
		issue(op_nop, 0, 0, 0, 0);
		repeat (3) @(negedge clk);
		$display("errors: mem=%0d hilo=%0d timeout=%0d", mem_errs, hilo_errs, timeouts);
		if (mem_errs == 0 && hilo_errs == 0 && timeouts == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* src.f */
source/lsu_pkg.sv
source/op_if.sv
source/op_decode.sv
source/store_lane.sv
source/hilo_unit.sv
source/load_extract.sv
source/mem_muldiv_top.sv
tests/tb_checker.sv
tests/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
RTL_TOP   ?= mem_muldiv_top
FLIST     ?= src.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
